//--- logic/csPkg.sv
package csPkg;

	// Latched address A23..A1, read either by region nibble or by video page layout
	typedef union packed {
		struct packed {
			logic [3:0]  region;	// A23..A20
			logic [18:0] rest;	// A19..A1, rest[0] is A1
		} regionView;
		struct packed {
			logic [7:0] page;	// A23..A16
			logic [3:0] block;	// A15..A12
			logic [3:0] subBlock;	// A11..A8
			logic [6:0] low;	// A7..A1
		} videoView;
	} busAddrT;

	// I/O region nibbles
	localparam logic [3:0] regionIack  = 4'hF;
	localparam logic [3:0] regionVia   = 4'hE;
	localparam logic [3:0] regionIwm   = 4'hD;
	localparam logic [3:0] regionSccWr = 4'hB;
	localparam logic [3:0] regionSccRd = 4'h9;
	localparam logic [3:0] regionScsi  = 4'h5;

	localparam logic [3:0] regionRom4x = 4'h4;	// ROM at 4xxxxx, RAM sits below it
	localparam logic [3:0] ioRealFirst = 4'h5;	// I/O-bus domain is 5..F

	// Video RAM page, 3F0000-3FFFFF
	localparam logic [7:0] videoPage = 8'h3F;

	// Sound buffer, upper copy in block F
	localparam logic [3:0] sndBlockHi  = 4'hF;
	localparam logic [3:0] sndSubHiMin = 4'hD;	// D, E, F
	// Lower copy in block A
	localparam logic [3:0] sndBlockLo  = 4'hA;
	localparam logic [3:0] sndSubLoMin = 4'h1;
	localparam logic [3:0] sndSubLoMax = 4'h3;

	// Level of A19 that selects the set-write inside region F
	localparam logic setA19Level = 1'b0;

endpackage

//--- logic/selIf.sv
`timescale 1ns/1ps

// Memory-space selects, combinational from the latched address
interface memSelIf;
	logic romCs;	// ROM, overlay or 4xxxxx
	logic romCs4x;	// ROM at its own region
	logic ramCs;	// RAM once overlay is gone
	logic ramCs0x;	// Low 4 MB, overlay ignored
	logic vidWr64k;	// Write anywhere in page 3F
	logic sndWr;	// Write to a sound sub-block

	modport src (
		output romCs, romCs4x, ramCs, ramCs0x, vidWr64k, sndWr
	);
	modport dst (
		input romCs, romCs4x, ramCs, ramCs0x, vidWr64k, sndWr
	);
endinterface

// I/O-space selects
interface ioSelIf;
	logic iackCs;
	logic iack0Cs;	// IACK with A1
	logic iack1Cs;	// IACK with A2
	logic viaCs;
	logic iwmCs;
	logic sccCs;	// Read and write regions together
	logic scsiCs;
	logic ioRealCs;	// Anywhere in 5..F
	logic setWr;

	modport src (
		output iackCs, iack0Cs, iack1Cs, viaCs, iwmCs, sccCs, scsiCs, ioRealCs, setWr
	);
	modport dst (
		input iackCs, iack0Cs, iack1Cs, viaCs, iwmCs, sccCs, scsiCs, ioRealCs, setWr
	);
endinterface

//--- logic/busCycle.sv
`timescale 1ns/1ps

module busCycle import csPkg::*; (
	input  logic         CLK,
	input  logic         rstN,
	input  logic [23:1]  addr,
	input  logic         nAs,
	input  logic         nWe,
	output busAddrT      busAddr,
	output logic         wr,
	output logic         bact
);

	logic cycleStart;

	// First edge with the strobe down
	assign cycleStart = !nAs && !bact;

	// Strobe sampled straight into bus activity
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			bact <= 1'b0;
		end else begin
			bact <= !nAs;
		end
	end

	// Address and direction held for the whole cycle
	always_ff @(posedge CLK) begin
		if (cycleStart) begin
			busAddr <= addr;
			wr      <= !nWe;	// nWe low means write
		end
	end

	// Decoders rely on a frozen address until the strobe goes away
	addrStable: assert property (@(posedge CLK) disable iff (!rstN)
		bact |=> $stable({busAddr, wr}))
		else $error("busCycle address changed during an active cycle");

endmodule

//--- logic/memDecode.sv
`timescale 1ns/1ps

module memDecode import csPkg::*; (
	input  logic    CLK,
	input  logic    rstN,
	input  busAddrT busAddr,
	input  logic    wr,
	input  logic    bact,
	memSelIf.src    mem
);

	logic       overlay;
	logic [3:0] region;
	logic       sndHi;
	logic       sndLo;

	assign region = busAddr.regionView.region;

	// Boot overlay, ROM shows up at address 0 until code jumps to 4xxxxx
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			overlay <= 1'b1;
		end else if (bact && mem.romCs4x) begin
			overlay <= 1'b0;	// First real ROM fetch ends it
		end
	end

	// ROM
	assign mem.romCs4x = region == regionRom4x;
	assign mem.romCs   = overlay || mem.romCs4x;	// Everywhere while overlaid

	// RAM covers regions 0..3
	assign mem.ramCs0x = region < regionRom4x;
	assign mem.ramCs   = mem.ramCs0x && !overlay;	// Hidden under the overlay

	// Video page writes
	assign mem.vidWr64k = (busAddr.videoView.page == videoPage) && wr;

	// Sound buffer sub-blocks inside the video page
	assign sndHi = (busAddr.videoView.block == sndBlockHi) &&
		(busAddr.videoView.subBlock >= sndSubHiMin);	// FD00-FFFF
	assign sndLo = (busAddr.videoView.block == sndBlockLo) &&
		(busAddr.videoView.subBlock >= sndSubLoMin) &&
		(busAddr.videoView.subBlock <= sndSubLoMax);	// A100-A3FF
	assign mem.sndWr = mem.vidWr64k && (sndHi || sndLo);

	// ROM and RAM share the data bus, never drive both
	romRamExcl: assert property (@(posedge CLK) disable iff (!rstN)
		bact |-> !(mem.romCs && mem.ramCs))
		else $error("memDecode selected ROM and RAM together");

endmodule

//--- logic/ioDecode.sv
`timescale 1ns/1ps

module ioDecode import csPkg::*; (
	input  busAddrT busAddr,
	input  logic    wr,
	ioSelIf.src     io
);

	logic [3:0] region;
	logic       a1;
	logic       a2;
	logic       a19;

	assign region = busAddr.regionView.region;
	assign a1     = busAddr.regionView.rest[0];
	assign a2     = busAddr.regionView.rest[1];
	assign a19    = busAddr.regionView.rest[18];

	// Interrupt acknowledge space, FC on the CPU side
	assign io.iackCs  = region == regionIack;
	assign io.iack0Cs = io.iackCs && a1;	// Level bit 0
	assign io.iack1Cs = io.iackCs && a2;	// Level bit 1

	// Peripheral chips
	assign io.viaCs  = region == regionVia;
	assign io.iwmCs  = region == regionIwm;
	assign io.scsiCs = region == regionScsi;

	// SCC sits in two regions, one for each direction
	assign io.sccCs = (region == regionSccWr) || (region == regionSccRd);

	// Whole I/O-bus domain, empty slots included
	assign io.ioRealCs = region >= ioRealFirst;

	// Set-write lives in the lower half of region F
	assign io.setWr = (region == regionIack) && (a19 == setA19Level) && wr;

endmodule

//--- logic/selectCombine.sv
`timescale 1ns/1ps

module selectCombine (
	input  logic CLK,
	input  logic rstN,
	input  logic bact,
	input  logic qosEn,
	memSelIf.dst mem,
	ioSelIf.dst  io,
	output logic romCs,
	output logic romCs4x,
	output logic ramCs,
	output logic ramCs0x,
	output logic iaCs,
	output logic iackCs,
	output logic iack0Cs,
	output logic iack1Cs,
	output logic viaCs,
	output logic iwmCs,
	output logic sccCs,
	output logic scsiCs,
	output logic ioRealCs,
	output logic ioCs,
	output logic ioPwCs,
	output logic sndCsWr,
	output logic setCsWr
);

	logic        ioCsNext;
	logic        ioPwCsNext;
	logic [16:0] selNext;
	logic [16:0] selQ;

	assign ioCsNext   = io.ioRealCs || mem.vidWr64k || qosEn;	// QoS pulls every access onto I/O
	assign ioPwCsNext = io.iackCs || (mem.vidWr64k && !qosEn);	// Posted video write only with QoS off

	// Same order on both sides of the register
	assign selNext = {mem.romCs, mem.romCs4x, mem.ramCs, mem.ramCs0x, io.iackCs,
		io.iackCs, io.iack0Cs, io.iack1Cs, io.viaCs, io.iwmCs, io.sccCs, io.scsiCs,
		io.ioRealCs, ioCsNext, ioPwCsNext, mem.sndWr, io.setWr};

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			selQ <= '0;
		end else begin
			selQ <= bact ? selNext : '0;	// Idle bus drops everything
		end
	end

	assign {romCs, romCs4x, ramCs, ramCs0x, iaCs, iackCs, iack0Cs, iack1Cs, viaCs, iwmCs,
		sccCs, scsiCs, ioRealCs, ioCs, ioPwCs, sndCsWr, setCsWr} = selQ;

	// Under QoS the only posted write left is IACK
	qosPw: assert property (@(posedge CLK) disable iff (!rstN)
		$rose(ioPwCs) && $past(qosEn) |-> iackCs)
		else $error("ioPwCs rose with qosEn set and no IACK");

endmodule

//--- logic/chipSelect.sv
`timescale 1ns/1ps

module chipSelect import csPkg::*; (
	input  logic        CLK,
	input  logic        rstN,
	input  logic [23:1] addr,
	input  logic        nAs,
	input  logic        nWe,
	input  logic        qosEn,
	output logic        busActive,
	output logic        romCs,
	output logic        romCs4x,
	output logic        ramCs,
	output logic        ramCs0x,
	output logic        iaCs,
	output logic        iackCs,
	output logic        iack0Cs,
	output logic        iack1Cs,
	output logic        viaCs,
	output logic        iwmCs,
	output logic        sccCs,
	output logic        scsiCs,
	output logic        ioRealCs,
	output logic        ioCs,
	output logic        ioPwCs,
	output logic        sndCsWr,
	output logic        setCsWr
);

	busAddrT busAddr;	// Held for the cycle
	logic    wr;
	logic    bact;

	memSelIf memSel ();
	ioSelIf  ioSel ();

	assign busActive = bact;

	busCycle busCycle_i (
		.CLK(CLK), .rstN(rstN), .addr(addr), .nAs(nAs), .nWe(nWe),
		.busAddr(busAddr), .wr(wr), .bact(bact)
	);

	// Two decoders in parallel off the same latched address
	memDecode memDecode_i (
		.CLK(CLK), .rstN(rstN), .busAddr(busAddr), .wr(wr), .bact(bact), .mem(memSel)
	);
	ioDecode ioDecode_i (
		.busAddr(busAddr), .wr(wr), .io(ioSel)
	);

	// Registered select outputs
	selectCombine selectCombine_i (
		.CLK(CLK), .rstN(rstN), .bact(bact), .qosEn(qosEn), .mem(memSel), .io(ioSel),
		.romCs(romCs), .romCs4x(romCs4x), .ramCs(ramCs), .ramCs0x(ramCs0x),
		.iaCs(iaCs), .iackCs(iackCs), .iack0Cs(iack0Cs), .iack1Cs(iack1Cs),
		.viaCs(viaCs), .iwmCs(iwmCs), .sccCs(sccCs), .scsiCs(scsiCs),
		.ioRealCs(ioRealCs), .ioCs(ioCs), .ioPwCs(ioPwCs),
		.sndCsWr(sndCsWr), .setCsWr(setCsWr)
	);

endmodule

//--- bench/csTests.svh
`ifndef csTestsSvh
`define csTestsSvh

// Boot overlay across reset, region 4 fetch and RAM accesses
task automatic overlayCycles();
	logic [31:0] rnd;
	logic [3:0]  region;
	logic        cleared;
	checkIdle();	// Nothing selected before the first strobe
	for (int n = 0; n < 5; n++) begin
		rnd = $urandom;
		if (n == 4) begin
			applyReset();	// Overlay comes back
			checkIdle();
		end
		region  = (n == 1) ? 4'h4 : (n == 3) ? 4'h3 : 4'h0;
		cleared = (n == 2) || (n == 3);	// After the region 4 fetch and before reset
		beginCycle({region, rnd[18:0]}, rnd[19], 1'b0);
		checkBit("romCs", romCs, !cleared);
		checkBit("ramCs", ramCs, cleared);
		checkBit("ramCs0x", ramCs0x, n != 1);
		checkBit("romCs4x", romCs4x, n == 1);
		endCycle();
	end
endtask

// Every region nibble against the I/O map
task automatic ioRegions();
	logic [31:0] rnd;
	logic [3:0]  region;
	logic [1:0]  a21;
	logic [4:0]  expIo;	// iack, via, iwm, scc, scsi
	for (int r = 0; r < 16; r++) begin
		for (int v = 0; v < ((r == 15) ? 4 : 1); v++) begin
			rnd    = $urandom;
			region = r[3:0];
			a21    = (r == 15) ? v[1:0] : rnd[1:0];	// All IACK levels in region F
			case (region)
				4'hF: expIo = 5'b10000;
				4'hE: expIo = 5'b01000;
				4'hD: expIo = 5'b00100;
				4'hB, 4'h9: expIo = 5'b00010;	// SCC write and read halves
				4'h5: expIo = 5'b00001;
				default: expIo = 5'b00000;
			endcase
			beginCycle({region, rnd[18:2], a21}, 1'b0, 1'b0);
			checkBit("iackCs", iackCs, expIo[4]);
			checkBit("iaCs", iaCs, expIo[4]);
			checkBit("iack0Cs", iack0Cs, expIo[4] && a21[0]);
			checkBit("iack1Cs", iack1Cs, expIo[4] && a21[1]);
			checkBit("viaCs", viaCs, expIo[3]);
			checkBit("iwmCs", iwmCs, expIo[2]);
			checkBit("sccCs", sccCs, expIo[1]);
			checkBit("scsiCs", scsiCs, expIo[0]);
			checkBit("ioRealCs", ioRealCs, region inside {[4'h5:4'hF]});
			endCycle();
		end
	end
endtask

// Sound sub-blocks in page 3F and then the set-write around region F
task automatic videoWrites();
	logic [31:0] rnd;
	logic [3:0]  blk;
	logic [3:0]  sub;
	logic [3:0]  region;
	logic        write;
	logic        a19;
	logic        inE;	// Neighbor region E in place of F
	logic        expSnd;
	for (int n = 0; n < 512; n++) begin
		rnd = $urandom;
		{blk, sub, write} = n[8:0];
		expSnd = write && ({blk, sub} inside {8'hFD, 8'hFE, 8'hFF, 8'hA1, 8'hA2, 8'hA3});
		beginCycle({8'h3F, blk, sub, rnd[6:0]}, write, 1'b0);
		checkBit("sndCsWr", sndCsWr, expSnd);
		checkBit("setCsWr", setCsWr, 1'b0);	// Page 3F lies in region 3
		endCycle();
	end
	for (int n = 0; n < 8; n++) begin
		rnd = $urandom;
		{inE, a19, write} = n[2:0];
		region = inE ? 4'hE : 4'hF;
		beginCycle({region, a19, rnd[17:0]}, write, 1'b0);
		checkBit("setCsWr", setCsWr, write && !a19 && (region == 4'hF));	// Lower half of F only
		checkBit("sndCsWr", sndCsWr, 1'b0);
		endCycle();
	end
endtask

// QoS on and off over a RAM read, a video write and an IACK read
task automatic qosMix();
	logic [31:0] rnd;
	logic [23:1] a;
	logic        vidWr;
	logic        iackRd;
	for (int q = 0; q < 2; q++) begin
		for (int kind = 0; kind < 3; kind++) begin
			rnd = $urandom;
			case (kind)
				0: a = {4'h0, rnd[18:0]};
				1: a = {8'h3F, rnd[14:0]};
				default: a = {4'hF, rnd[18:0]};
			endcase
			vidWr  = kind == 1;
			iackRd = kind == 2;	// Region F also sits in the I/O-bus domain
			beginCycle(a, vidWr, q[0]);
			checkBit("ioCs", ioCs, iackRd || vidWr || q[0]);
			checkBit("ioPwCs", ioPwCs, iackRd || (vidWr && !q[0]));
			endCycle();
		end
	end
endtask

`endif

//--- bench/chipSelectTb.sv
`timescale 1ns/1ps

module chipSelectTb;

	localparam int clkPeriod   = 20;
	localparam int resetCycles = 8;
	localparam int busCycles   = 550;	// 5 + 19 + 520 + 6 bus cycles over all tests
	localparam int timeoutNs   = (busCycles * 200 + 4 * resetCycles) * clkPeriod;

	logic        CLK;
	logic        rstN;
	logic [23:1] addr;
	logic        nAs;
	logic        nWe;
	logic        qosEn;
	logic        busActive;
	logic        romCs, romCs4x, ramCs, ramCs0x;	// Memory space
	logic        iaCs, iackCs, iack0Cs, iack1Cs;	// Interrupt acknowledge
	logic        viaCs, iwmCs, sccCs, scsiCs;	// Peripheral chips
	logic        ioRealCs, ioCs, ioPwCs, sndCsWr, setCsWr;

	int checkCount = 0;
	int errorCount = 0;

	chipSelect chipSelect_i (.*);

	always #(clkPeriod / 2) CLK = !CLK;

	`include "csTests.svh"

	task automatic checkBit(input string name, input logic got, input logic exp);
		checkCount++;
		assert (got === exp) else begin
			errorCount++;
			$display("CHECK FAILED %s: got %h, expected %h at %0t ns", name, got, exp, $time);
		end
	endtask

	// Whole output set low with busActive in the top bit
	task automatic checkIdle();
		logic [17:0] outs;
		outs = {busActive, romCs, romCs4x, ramCs, ramCs0x, iaCs, iackCs, iack0Cs, iack1Cs,
			viaCs, iwmCs, sccCs, scsiCs, ioRealCs, ioCs, ioPwCs, sndCsWr, setCsWr};
		checkCount++;
		assert (outs === '0) else begin
			errorCount++;
			$display("CHECK FAILED {busActive, selects}: got %h, expected %h at %0t ns",
				outs, 18'h0, $time);
		end
	endtask

	task automatic applyReset();
		@(posedge CLK);
		rstN <= 1'b0;
		repeat (resetCycles) @(posedge CLK);
		rstN <= 1'b1;
		@(negedge CLK);	// Settled with no strobe yet
	endtask

	// Strobe seen low at edge k and selects read after edge k+2
	task automatic beginCycle(input logic [23:1] a, input logic write, input logic qos);
		@(posedge CLK);
		addr  <= a;
		nWe   <= !write;
		qosEn <= qos;
		nAs   <= 1'b0;
		@(negedge CLK);
		while (busActive !== 1'b1) @(negedge CLK);	// Edge k has passed
		@(posedge CLK);
		@(posedge CLK);
		nAs <= 1'b1;	// Low for edges k..k+2 and high from m
		@(negedge CLK);
		checkBit("busActive", busActive, 1'b1);	// Still inside the cycle
	endtask

	// Edge m drops busActive and edge m+1 drops every select
	task automatic endCycle();
		@(posedge CLK);
		@(posedge CLK);
		@(negedge CLK);
		checkIdle();
	endtask

	initial begin
		void'($urandom(45550));
		CLK   = 1'b0;
		rstN  = 1'b0;
		addr  = '0;
		nAs   = 1'b1;
		nWe   = 1'b1;
		qosEn = 1'b0;
		applyReset();
		overlayCycles();
		ioRegions();
		videoWrites();
		qosMix();
		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	// Watchdog against a strobe that never shows up as busActive
	initial begin
		#(timeoutNs);
		$display("Timeout, bus cycles stalled: checks run: %0d, errors: %0d",
			checkCount, errorCount);
		$display("Errors found");
		$finish;
	end

endmodule

//--- src.f
+incdir+bench
logic/csPkg.sv
logic/selIf.sv
logic/busCycle.sv
logic/memDecode.sv
logic/ioDecode.sv
logic/selectCombine.sv
logic/chipSelect.sv
bench/chipSelectTb.sv

//--- run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

buildDir=build
logFile=sim.log

verilator --binary --timing --assert --top-module chipSelectTb \
	-Mdir "$buildDir" -o chipSelectSim -f src.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"$buildDir/chipSelectSim" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "Errors found" "$logFile"; then
	echo "Simulation reported failing checks, see $logFile"
	exit 1
fi
echo "Simulation passed"
exit 0
